/* hdl/rv_pkg.sv */
package rv_pkg;

    // data path and register file
    parameter int XLEN_DEFAULT   = 64;
    parameter int REG_ADDR_WIDTH = 5;
    parameter int ALU_OP_WIDTH   = 4;

    typedef enum logic [ALU_OP_WIDTH-1:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_SLT   = 4'd8,
        ALU_SLTU  = 4'd9,
        ALU_PASS2 = 4'd10 // lui passes source 2
    } alu_op_e;

    // major opcodes in instr[6:0]
    parameter logic [6:0] OPC_OP        = 7'b0110011;
    parameter logic [6:0] OPC_OP_IMM    = 7'b0010011;
    parameter logic [6:0] OPC_OP_32     = 7'b0111011;
    parameter logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    parameter logic [6:0] OPC_LUI       = 7'b0110111;

    // host word address map
    parameter int ADDR_WIDTH = 8;

    parameter logic [ADDR_WIDTH-1:0] ADR_INSTR    = 8'd0;
    parameter logic [ADDR_WIDTH-1:0] ADR_RETIRED  = 8'd1;
    parameter logic [ADDR_WIDTH-1:0] ADR_ILLEGAL  = 8'd2;
    parameter logic [ADDR_WIDTH-1:0] ADR_GPR_BASE = 8'd32; // x0..x31 at 32..63

endpackage

/* hdl/rv_decode_stage.sv */
`timescale 1ns/1ns

module rv_decode_stage #(
    parameter int XLEN = rv_pkg::XLEN_DEFAULT
) (
    input  logic                              issue_i,
    input  logic [31:0]                       instr_i,
    input  logic [XLEN-1:0]                   rs1_rdata_i,
    input  logic [XLEN-1:0]                   rs2_rdata_i,
    input  logic                              ex_valid_i,
    input  logic                              ex_rd_we_i,
    input  logic [rv_pkg::REG_ADDR_WIDTH-1:0] ex_rd_addr_i,
    input  logic [XLEN-1:0]                   ex_result_i,
    output logic [rv_pkg::REG_ADDR_WIDTH-1:0] rs1_addr_o,
    output logic [rv_pkg::REG_ADDR_WIDTH-1:0] rs2_addr_o,
    output logic                              valid_o,
    output logic                              rd_we_o,
    output logic [rv_pkg::REG_ADDR_WIDTH-1:0] rd_addr_o,
    output rv_pkg::alu_op_e                   alu_op_o,
    output logic                              word_op_o,
    output logic                              illegal_o,
    output logic [XLEN-1:0]                   alu_src1_o,
    output logic [XLEN-1:0]                   alu_src2_o
);

    localparam bit IS_RV64 = (XLEN == 64); // word forms exist only on rv64

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            alt_r;      // sub / sra select in register form
    logic            alt_i;      // srai select in immediate form
    logic            r_f7_ok;
    logic            word_f3;
    logic            shamt_ok;
    logic            imm_sel;
    logic            lui_sel;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;

    function automatic rv_pkg::alu_op_e f3_to_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  f3_to_op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  f3_to_op = rv_pkg::ALU_SLL;
            3'b010:  f3_to_op = rv_pkg::ALU_SLT;
            3'b011:  f3_to_op = rv_pkg::ALU_SLTU;
            3'b100:  f3_to_op = rv_pkg::ALU_XOR;
            3'b101:  f3_to_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  f3_to_op = rv_pkg::ALU_OR;
            default: f3_to_op = rv_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode     = instr_i[6:0];
    assign funct3     = instr_i[14:12];
    assign funct7     = instr_i[31:25];
    assign rd_addr_o  = instr_i[11:7];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    assign alt_r    = funct7[5];
    assign alt_i    = (funct3 == 3'b101) && instr_i[30]; // addi imm bit 30 is not a select
    assign r_f7_ok  = (funct7 == 7'b0000000) ||
                      (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
    assign word_f3  = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101);
    assign shamt_ok = ((instr_i[31:26] == 6'b000000) ||
                       (funct3 == 3'b101 && instr_i[31:26] == 6'b010000)) &&
                      (IS_RV64 || !instr_i[25]);

    always_comb begin
        alu_op_o  = rv_pkg::ALU_ADD;
        word_op_o = 1'b0;
        imm_sel   = 1'b0;
        lui_sel   = 1'b0;
        illegal_o = 1'b0;
        case (opcode)
            rv_pkg::OPC_OP: begin
                alu_op_o  = f3_to_op(funct3, alt_r);
                illegal_o = !r_f7_ok;
            end
            rv_pkg::OPC_OP_32: begin
                alu_op_o  = f3_to_op(funct3, alt_r);
                word_op_o = 1'b1;
                illegal_o = !(IS_RV64 && word_f3 && r_f7_ok);
            end
            rv_pkg::OPC_OP_IMM: begin
                alu_op_o  = f3_to_op(funct3, alt_i);
                imm_sel   = 1'b1;
                illegal_o = (funct3 == 3'b001 || funct3 == 3'b101) && !shamt_ok;
            end
            rv_pkg::OPC_OP_IMM_32: begin
                alu_op_o  = f3_to_op(funct3, alt_i);
                word_op_o = 1'b1;
                imm_sel   = 1'b1;
                illegal_o = !(IS_RV64 && word_f3 && (funct3 == 3'b000 || r_f7_ok));
            end
            rv_pkg::OPC_LUI: begin
                alu_op_o = rv_pkg::ALU_PASS2;
                lui_sel  = 1'b1;
            end
            default: illegal_o = 1'b1; // stores, branches, system, ...
        endcase
    end

    assign imm_i = XLEN'($signed(instr_i[31:20]));
    assign imm_u = XLEN'($signed({instr_i[31:12], 12'b0}));

    // execute result wins over the register file; rd is never x0 when ex_rd_we_i
    assign rs1_val = (ex_valid_i && ex_rd_we_i && ex_rd_addr_i == rs1_addr_o) ?
                     ex_result_i : rs1_rdata_i;
    assign rs2_val = (ex_valid_i && ex_rd_we_i && ex_rd_addr_i == rs2_addr_o) ?
                     ex_result_i : rs2_rdata_i;

    assign alu_src1_o = rs1_val;
    assign alu_src2_o = lui_sel ? imm_u : (imm_sel ? imm_i : rs2_val);

    assign valid_o = issue_i;
    assign rd_we_o = issue_i && !illegal_o && (rd_addr_o != '0); // no x0 writes

endmodule

/* hdl/rv_regfile.sv */
`timescale 1ns/1ns

module rv_regfile #(
    parameter int XLEN = rv_pkg::XLEN_DEFAULT
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [rv_pkg::REG_ADDR_WIDTH-1:0] raddr1_i,
    input  logic [rv_pkg::REG_ADDR_WIDTH-1:0] raddr2_i,
    input  logic [rv_pkg::REG_ADDR_WIDTH-1:0] raddr3_i,
    input  logic                              we_i,
    input  logic [rv_pkg::REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [XLEN-1:0]                   wdata_i,
    output logic [XLEN-1:0]                   rdata1_o,
    output logic [XLEN-1:0]                   rdata2_o,
    output logic [XLEN-1:0]                   rdata3_o
);

    logic [XLEN-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i]; // hardwired zero
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];
    assign rdata3_o = (raddr3_i == '0) ? '0 : regs[raddr3_i]; // host readback

endmodule

/* hdl/id_ex_regs.sv */
`timescale 1ns/1ns

module id_ex_regs #(
    parameter int XLEN = rv_pkg::XLEN_DEFAULT
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              valid_i,
    input  logic                              rd_we_i,
    input  logic [rv_pkg::REG_ADDR_WIDTH-1:0] rd_addr_i,
    input  rv_pkg::alu_op_e                   alu_op_i,
    input  logic                              word_op_i,
    input  logic                              illegal_i,
    input  logic [XLEN-1:0]                   alu_src1_i,
    input  logic [XLEN-1:0]                   alu_src2_i,
    output logic                              valid_o,
    output logic                              rd_we_o,
    output logic [rv_pkg::REG_ADDR_WIDTH-1:0] rd_addr_o,
    output rv_pkg::alu_op_e                   alu_op_o,
    output logic                              word_op_o,
    output logic                              illegal_o,
    output logic [XLEN-1:0]                   alu_src1_o,
    output logic [XLEN-1:0]                   alu_src2_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o    <= 1'b0;
            rd_we_o    <= 1'b0;
            rd_addr_o  <= '0;
            alu_op_o   <= rv_pkg::ALU_ADD;
            word_op_o  <= 1'b0;
            illegal_o  <= 1'b0;
            alu_src1_o <= '0;
            alu_src2_o <= '0;
        end else begin
            valid_o    <= valid_i;            // low on cycles without issue
            rd_we_o    <= valid_i && rd_we_i; // bubbles never write
            rd_addr_o  <= rd_addr_i;
            alu_op_o   <= alu_op_i;
            word_op_o  <= word_op_i;
            illegal_o  <= illegal_i;
            alu_src1_o <= alu_src1_i;
            alu_src2_o <= alu_src2_i;
        end
    end

endmodule

/* hdl/rv_alu.sv */
`timescale 1ns/1ns

module rv_alu #(
    parameter int XLEN = rv_pkg::XLEN_DEFAULT
) (
    input  rv_pkg::alu_op_e  alu_op_i,
    input  logic             word_op_i,
    input  logic [XLEN-1:0]  src1_i,
    input  logic [XLEN-1:0]  src2_i,
    output logic [XLEN-1:0]  result_o
);

    localparam int SHW = $clog2(XLEN); // 6 bit shamt on rv64

    logic [SHW-1:0]  shamt;
    logic [4:0]      shamt_w;
    logic [31:0]     w1;
    logic [31:0]     w2;
    logic [XLEN-1:0] res_full;
    logic [31:0]     res_word;

    assign shamt   = src2_i[SHW-1:0];
    assign shamt_w = src2_i[4:0];
    assign w1      = src1_i[31:0];
    assign w2      = src2_i[31:0];

    always_comb begin
        case (alu_op_i)
            rv_pkg::ALU_ADD:   res_full = src1_i + src2_i;
            rv_pkg::ALU_SUB:   res_full = src1_i - src2_i;
            rv_pkg::ALU_AND:   res_full = src1_i & src2_i;
            rv_pkg::ALU_OR:    res_full = src1_i | src2_i;
            rv_pkg::ALU_XOR:   res_full = src1_i ^ src2_i;
            rv_pkg::ALU_SLL:   res_full = src1_i << shamt;
            rv_pkg::ALU_SRL:   res_full = src1_i >> shamt;
            rv_pkg::ALU_SRA:   res_full = XLEN'($signed(src1_i) >>> shamt);
            rv_pkg::ALU_SLT:   res_full = XLEN'($signed(src1_i) < $signed(src2_i));
            rv_pkg::ALU_SLTU:  res_full = XLEN'(src1_i < src2_i);
            default:           res_full = src2_i; // pass2 for lui
        endcase
    end

    // word forms only use add/sub and shifts
    always_comb begin
        case (alu_op_i)
            rv_pkg::ALU_SUB: res_word = w1 - w2;
            rv_pkg::ALU_SLL: res_word = w1 << shamt_w;
            rv_pkg::ALU_SRL: res_word = w1 >> shamt_w;
            rv_pkg::ALU_SRA: res_word = 32'($signed(w1) >>> shamt_w);
            default:         res_word = w1 + w2;
        endcase
    end

    assign result_o = word_op_i ? XLEN'($signed(res_word)) : res_full; // sext 32 -> xlen

endmodule

/* hdl/rv_host_regs.sv */
`timescale 1ns/1ns

module rv_host_regs #(
    parameter int XLEN = rv_pkg::XLEN_DEFAULT
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              wb_cyc_i,
    input  logic                              wb_stb_i,
    input  logic                              wb_we_i,
    input  logic [rv_pkg::ADDR_WIDTH-1:0]     wb_adr_i,
    input  logic [XLEN-1:0]                   wb_dat_i,
    input  logic                              ex_valid_i,
    input  logic                              ex_illegal_i,
    input  logic [XLEN-1:0]                   gpr_rdata_i,
    output logic [XLEN-1:0]                   wb_dat_o,
    output logic                              wb_ack_o,
    output logic                              issue_o,
    output logic [31:0]                       instr_o,
    output logic [rv_pkg::REG_ADDR_WIDTH-1:0] gpr_raddr_o
);

    logic            wr_req;
    logic            rd_req;
    logic            busy;
    logic            is_gpr;
    logic            rd_ack_q;
    logic [XLEN-1:0] rd_data_q;
    logic [XLEN-1:0] rd_mux;
    logic [XLEN-1:0] retired_q;
    logic [XLEN-1:0] illegal_q;

    assign wr_req = wb_cyc_i && wb_stb_i && wb_we_i;
    assign rd_req = wb_cyc_i && wb_stb_i && !wb_we_i;

    assign issue_o = wr_req && (wb_adr_i == rv_pkg::ADR_INSTR); // one cycle per write
    assign instr_o = wb_dat_i[31:0];
    assign busy    = issue_o || ex_valid_i;

    assign is_gpr      = (wb_adr_i >= rv_pkg::ADR_GPR_BASE) &&
                         (wb_adr_i < rv_pkg::ADR_GPR_BASE + 8'd32);
    assign gpr_raddr_o = wb_adr_i[rv_pkg::REG_ADDR_WIDTH-1:0];

    always_comb begin
        if (is_gpr) begin
            rd_mux = gpr_rdata_i;
        end else if (wb_adr_i == rv_pkg::ADR_RETIRED) begin
            rd_mux = retired_q;
        end else if (wb_adr_i == rv_pkg::ADR_ILLEGAL) begin
            rd_mux = illegal_q;
        end else begin
            rd_mux = '0; // unmapped
        end
    end

    // read ack waits until the pipeline has drained
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ack_q <= 1'b0;
        end else begin
            rd_ack_q <= rd_req && !rd_ack_q && !busy;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req && !rd_ack_q && !busy) begin
            rd_data_q <= rd_mux;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retired_q <= '0;
            illegal_q <= '0;
        end else if (ex_valid_i) begin
            if (ex_illegal_i) begin
                illegal_q <= illegal_q + 1'b1;
            end else begin
                retired_q <= retired_q + 1'b1;
            end
        end
    end

    assign wb_ack_o = wr_req || rd_ack_q; // every write acks at once
    assign wb_dat_o = rd_data_q;

endmodule

/* hdl/rv_exec_top.sv */
`timescale 1ns/1ns

module rv_exec_top #(
    parameter int XLEN = rv_pkg::XLEN_DEFAULT
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  logic [rv_pkg::ADDR_WIDTH-1:0] wb_adr_i,
    input  logic [XLEN-1:0]               wb_dat_i,
    output logic [XLEN-1:0]               wb_dat_o,
    output logic                          wb_ack_o
);

    logic                              issue;
    logic [31:0]                       instr;
    logic [rv_pkg::REG_ADDR_WIDTH-1:0] gpr_raddr;
    logic [XLEN-1:0]                   gpr_rdata;
    logic [rv_pkg::REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [rv_pkg::REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [XLEN-1:0]                   rs1_rdata;
    logic [XLEN-1:0]                   rs2_rdata;
    // decode side of id/ex
    logic                              id_valid;
    logic                              id_rd_we;
    logic [rv_pkg::REG_ADDR_WIDTH-1:0] id_rd_addr;
    rv_pkg::alu_op_e                   id_alu_op;
    logic                              id_word_op;
    logic                              id_illegal;
    logic [XLEN-1:0]                   id_src1;
    logic [XLEN-1:0]                   id_src2;
    // execute side
    logic                              ex_valid;
    logic                              ex_rd_we;
    logic [rv_pkg::REG_ADDR_WIDTH-1:0] ex_rd_addr;
    rv_pkg::alu_op_e                   ex_alu_op;
    logic                              ex_word_op;
    logic                              ex_illegal;
    logic [XLEN-1:0]                   ex_src1;
    logic [XLEN-1:0]                   ex_src2;
    logic [XLEN-1:0]                   ex_result;

    rv_host_regs #(.XLEN(XLEN)) rv_host_regs_i (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
        .ex_valid_i(ex_valid), .ex_illegal_i(ex_illegal), .gpr_rdata_i(gpr_rdata),
        .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .issue_o(issue), .instr_o(instr), .gpr_raddr_o(gpr_raddr)
    );

    rv_decode_stage #(.XLEN(XLEN)) rv_decode_stage_i (
        .issue_i(issue), .instr_i(instr),
        .rs1_rdata_i(rs1_rdata), .rs2_rdata_i(rs2_rdata),
        .ex_valid_i(ex_valid), .ex_rd_we_i(ex_rd_we),
        .ex_rd_addr_i(ex_rd_addr), .ex_result_i(ex_result),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .valid_o(id_valid), .rd_we_o(id_rd_we), .rd_addr_o(id_rd_addr),
        .alu_op_o(id_alu_op), .word_op_o(id_word_op), .illegal_o(id_illegal),
        .alu_src1_o(id_src1), .alu_src2_o(id_src2)
    );

    rv_regfile #(.XLEN(XLEN)) rv_regfile_i (
        .clk(clk), .rst_n(rst_n),
        .raddr1_i(rs1_addr), .raddr2_i(rs2_addr), .raddr3_i(gpr_raddr),
        .we_i(ex_rd_we), .waddr_i(ex_rd_addr), .wdata_i(ex_result),
        .rdata1_o(rs1_rdata), .rdata2_o(rs2_rdata), .rdata3_o(gpr_rdata)
    );

    id_ex_regs #(.XLEN(XLEN)) id_ex_regs_i (
        .clk(clk), .rst_n(rst_n),
        .valid_i(id_valid), .rd_we_i(id_rd_we), .rd_addr_i(id_rd_addr),
        .alu_op_i(id_alu_op), .word_op_i(id_word_op), .illegal_i(id_illegal),
        .alu_src1_i(id_src1), .alu_src2_i(id_src2),
        .valid_o(ex_valid), .rd_we_o(ex_rd_we), .rd_addr_o(ex_rd_addr),
        .alu_op_o(ex_alu_op), .word_op_o(ex_word_op), .illegal_o(ex_illegal),
        .alu_src1_o(ex_src1), .alu_src2_o(ex_src2)
    );

    rv_alu #(.XLEN(XLEN)) rv_alu_i (
        .alu_op_i(ex_alu_op), .word_op_i(ex_word_op),
        .src1_i(ex_src1), .src2_i(ex_src2),
        .result_o(ex_result) // write back and bypass
    );

endmodule

/* testbench/tb_rv_exec_top.sv */
`timescale 1ns/1ns

module tb_rv_exec_top;

    localparam int XLEN = 64;

    // major opcodes used by the stimulus
    localparam logic [6:0] OP     = rv_pkg::OPC_OP;
    localparam logic [6:0] OPI    = rv_pkg::OPC_OP_IMM;
    localparam logic [6:0] OP32   = rv_pkg::OPC_OP_32;
    localparam logic [6:0] OPI32  = rv_pkg::OPC_OP_IMM_32;
    localparam logic [6:0] LUI    = rv_pkg::OPC_LUI;
    localparam logic [6:0] STORE  = 7'b0100011;
    localparam logic [6:0] BRANCH = 7'b1100011;
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef struct packed {
        logic                          we;
        logic [rv_pkg::ADDR_WIDTH-1:0] adr;
        logic [XLEN-1:0]               dat;
        logic [XLEN-1:0]               exp;
        logic [3:0]                    test;
        logic                          tight; // no idle cycles before this step
    } step_t;

    logic                          clk = 1'b0;
    logic                          rst_n;
    logic                          wb_cyc;
    logic                          wb_stb;
    logic                          wb_we;
    logic [rv_pkg::ADDR_WIDTH-1:0] wb_adr;
    logic [XLEN-1:0]               wb_dat_w;
    logic [XLEN-1:0]               wb_dat_r;
    logic                          wb_ack;

    step_t       steps[$];
    logic [3:0]  build_test;
    logic [31:0] rand_state = 32'h8c59;
    int          cycles = 0;
    int          cycle_limit = 1000000;
    int          checks = 0;
    int          errors = 0;
    int          test_checks[1:6];
    int          test_errors[1:6];

    rv_exec_top #(.XLEN(XLEN)) rv_exec_top_i (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
        .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
        .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the bus did not finish the table within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] opc, input logic [6:0] f7,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        r_type = {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        i_type = {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
        u_type = {imm, rd, LUI};
    endfunction

    function automatic logic [7:0] gpr(input int n);
        gpr = rv_pkg::ADR_GPR_BASE + 8'(n);
    endfunction

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        next_rand = s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic issue(input logic [31:0] word, input logic tight);
        steps.push_back('{1'b1, rv_pkg::ADR_INSTR, {32'b0, word}, '0, build_test, tight});
    endtask

    task automatic poke(input logic [7:0] adr, input logic [XLEN-1:0] val);
        steps.push_back('{1'b1, adr, val, '0, build_test, 1'b0});
    endtask

    task automatic check_at(input logic [7:0] adr, input logic [XLEN-1:0] val,
                            input logic tight);
        steps.push_back('{1'b0, adr, '0, val, build_test, tight});
    endtask

    task automatic wait_ack();
        do @(negedge clk); while (wb_ack !== 1'b1); // ack is stable mid cycle
    endtask

    task automatic release_bus();
        @(posedge clk);
        #5;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic send_word(input logic [7:0] adr, input logic [XLEN-1:0] dat);
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_we    = 1'b1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wait_ack();
        release_bus();
    endtask

    task automatic fetch_word(input logic [7:0] adr, output logic [XLEN-1:0] dat);
        wb_adr = adr;
        wb_we  = 1'b0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wait_ack();
        dat = wb_dat_r;
        release_bus();
    endtask

    task automatic report_test(input int t);
        $display("test %0d done: %0d reads checked, %0d errors", t, test_checks[t],
                 test_errors[t]);
    endtask

    task automatic build_table();
        build_test = 4'd1; // reset state
        check_at(gpr(1), '0, 1'b0);
        check_at(gpr(31), '0, 1'b0);
        check_at(rv_pkg::ADR_RETIRED, '0, 1'b0);
        check_at(rv_pkg::ADR_ILLEGAL, '0, 1'b0);

        build_test = 4'd2; // one of each operation
        issue(i_type(OPI, 3'b000, 5'd1, 5'd0, 12'd100), 1'b0);
        issue(i_type(OPI, 3'b000, 5'd2, 5'd0, 12'hff9), 1'b0);   // -7
        issue(u_type(5'd3, 20'h80000), 1'b0);
        issue(i_type(OPI, 3'b000, 5'd4, 5'd0, 12'd5), 1'b0);
        issue(r_type(OP, 7'd0, 3'b000, 5'd5, 5'd1, 5'd2), 1'b0);   // add
        issue(r_type(OP, F7_ALT, 3'b000, 5'd6, 5'd1, 5'd2), 1'b0); // sub
        issue(r_type(OP, 7'd0, 3'b111, 5'd7, 5'd1, 5'd4), 1'b0);   // and
        issue(r_type(OP, 7'd0, 3'b110, 5'd8, 5'd1, 5'd4), 1'b0);   // or
        issue(r_type(OP, 7'd0, 3'b100, 5'd9, 5'd1, 5'd4), 1'b0);   // xor
        issue(r_type(OP, 7'd0, 3'b001, 5'd10, 5'd1, 5'd4), 1'b0);  // sll
        issue(r_type(OP, 7'd0, 3'b101, 5'd11, 5'd2, 5'd4), 1'b0);  // srl
        issue(r_type(OP, F7_ALT, 3'b101, 5'd12, 5'd3, 5'd4), 1'b0); // sra
        issue(r_type(OP, 7'd0, 3'b010, 5'd13, 5'd2, 5'd1), 1'b0);  // slt
        issue(r_type(OP, 7'd0, 3'b011, 5'd14, 5'd2, 5'd1), 1'b0);  // sltu
        issue(u_type(5'd16, 20'h7ffff), 1'b0);
        issue(r_type(OP32, 7'd0, 3'b000, 5'd15, 5'd16, 5'd16), 1'b0); // addw
        issue(i_type(OPI, 3'b000, 5'd18, 5'd3, 12'hfff), 1'b0);
        issue(i_type(OPI32, 3'b000, 5'd17, 5'd18, 12'd1), 1'b0);      // addiw
        check_at(gpr(3), 64'hffff_ffff_8000_0000, 1'b0);
        check_at(gpr(5), 64'h5d, 1'b0);
        check_at(gpr(6), 64'h6b, 1'b0);
        check_at(gpr(7), 64'h4, 1'b0);
        check_at(gpr(8), 64'h65, 1'b0);
        check_at(gpr(9), 64'h61, 1'b0);
        check_at(gpr(10), 64'hc80, 1'b0);
        check_at(gpr(11), 64'h07ff_ffff_ffff_ffff, 1'b0);
        check_at(gpr(12), 64'hffff_ffff_fc00_0000, 1'b0);
        check_at(gpr(13), 64'h1, 1'b0);
        check_at(gpr(14), 64'h0, 1'b0);
        check_at(gpr(15), 64'hffff_ffff_ffff_e000, 1'b0);
        check_at(gpr(17), 64'hffff_ffff_8000_0000, 1'b0);
        check_at(gpr(18), 64'hffff_ffff_7fff_ffff, 1'b0);

        build_test = 4'd3; // dependent chain issued back to back
        issue(i_type(OPI, 3'b000, 5'd20, 5'd0, 12'd1), 1'b0);
        issue(r_type(OP, 7'd0, 3'b000, 5'd20, 5'd20, 5'd20), 1'b1);
        issue(r_type(OP, 7'd0, 3'b000, 5'd20, 5'd20, 5'd20), 1'b1);
        issue(i_type(OPI, 3'b001, 5'd21, 5'd20, 12'd4), 1'b1);         // slli
        issue(r_type(OP, F7_ALT, 3'b000, 5'd22, 5'd21, 5'd20), 1'b1);
        issue(r_type(OP, 7'd0, 3'b100, 5'd22, 5'd22, 5'd21), 1'b1);
        issue(r_type(OP, 7'd0, 3'b111, 5'd23, 5'd21, 5'd22), 1'b1);
        check_at(gpr(20), 64'd4, 1'b0);
        check_at(gpr(21), 64'd64, 1'b0);
        check_at(gpr(22), 64'd124, 1'b0);
        check_at(gpr(23), 64'd64, 1'b0);

        build_test = 4'd4; // x0 stays zero
        issue(i_type(OPI, 3'b000, 5'd0, 5'd1, 12'd55), 1'b0);
        issue(r_type(OP, 7'd0, 3'b000, 5'd24, 5'd0, 5'd1), 1'b1);
        check_at(gpr(0), '0, 1'b0);
        check_at(gpr(24), 64'h64, 1'b0);

        build_test = 4'd5; // sw and beq with rd field aimed at x5 and x7
        issue(r_type(STORE, 7'd0, 3'b010, 5'd5, 5'd1, 5'd6), 1'b0);
        issue(r_type(BRANCH, 7'd0, 3'b000, 5'd7, 5'd1, 5'd1), 1'b1);
        check_at(gpr(5), 64'h5d, 1'b0);
        check_at(gpr(7), 64'h4, 1'b0);
        check_at(rv_pkg::ADR_ILLEGAL, 64'd2, 1'b0);
        check_at(rv_pkg::ADR_RETIRED, 64'd27, 1'b0);

        build_test = 4'd6; // read stall and read-only addresses
        issue(i_type(OPI, 3'b000, 5'd25, 5'd0, 12'h123), 1'b0);
        check_at(gpr(25), 64'h123, 1'b1);
        poke(rv_pkg::ADR_RETIRED, 64'hdead);
        poke(rv_pkg::ADR_ILLEGAL, 64'hbeef);
        poke(gpr(25), '0);
        check_at(rv_pkg::ADR_RETIRED, 64'd28, 1'b0);
        check_at(rv_pkg::ADR_ILLEGAL, 64'd2, 1'b0);
        check_at(gpr(25), 64'h123, 1'b0);
    endtask

    initial begin
        step_t           s;
        logic [XLEN-1:0] rdat;
        int              gap;
        int              cur;

        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        build_table();
        cycle_limit = steps.size() * 20 + 8;

        repeat (8) @(posedge clk);
        #5;
        rst_n = 1'b1;
        @(posedge clk);
        #5;

        cur = steps[0].test;
        foreach (steps[i]) begin
            s = steps[i];
            if (s.test != cur) begin
                report_test(cur);
                cur = s.test;
            end
            if (!s.tight) begin
                rand_state = next_rand(rand_state);
                gap = rand_state[17:16]; // 0 to 3 idle cycles
                repeat (gap) begin
                    @(posedge clk);
                    #5;
                end
            end
            if (s.we) begin
                send_word(s.adr, s.dat);
            end else begin
                fetch_word(s.adr, rdat);
                checks++;
                test_checks[s.test]++;
                assert (rdat === s.exp) else begin
                    $display("Mismatch test %0d adr %h: wb_dat_o = %h, expected %h",
                             s.test, s.adr, rdat, s.exp);
                    errors++;
                    test_errors[s.test]++;
                end
            end
        end
        report_test(cur);

        $display("summary: %0d tests, %0d checks, %0d errors", cur, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/rv_pkg.sv
hdl/rv_decode_stage.sv
hdl/rv_regfile.sv
hdl/id_ex_regs.sv
hdl/rv_alu.sv
hdl/rv_host_regs.sv
hdl/rv_exec_top.sv
testbench/tb_rv_exec_top.sv

/* Bender.yml */
package:
  name: rv_exec_slice

sources:
  - files:
      - hdl/rv_pkg.sv
      - hdl/rv_decode_stage.sv
      - hdl/rv_regfile.sv
      - hdl/id_ex_regs.sv
      - hdl/rv_alu.sv
      - hdl/rv_host_regs.sv
      - hdl/rv_exec_top.sv
  - target: test
    files:
      - testbench/tb_rv_exec_top.sv
